//--- Bender.yml
package:
  name: bypass_controller

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/bypass_pkg.sv
      - rtl/electrode_group_table.sv
      - rtl/spi_word_engine.sv
      - rtl/outcome_tally.sv
      - rtl/bypass_controller.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - testbench/bypass_assertions.sv
      - testbench/tb_bypass_controller.sv

//--- rtl/bypass_consts.svh
`ifndef BYPASS_CONSTS_SVH
`define BYPASS_CONSTS_SVH

// --------------------
// word and table sizes
// --------------------
`define BYPASS_WORD_BITS     32  // spi word and host command
`define BYPASS_GROUPS        10  // electrode groups held in the table
`define BYPASS_GROUP_BITS    4   // group number width, 0..15 on the wire

// --------------------
// command word fields
// --------------------
`define BYPASS_OPCODE_MSB    31
`define BYPASS_OPCODE_LSB    28
`define BYPASS_GROUP_MSB     27
`define BYPASS_GROUP_LSB     24
`define BYPASS_FUNC_MSB      23
`define BYPASS_FUNC_LSB      22  // bits 21..0 are don't care

// --------------------
// timing and counters
// --------------------
`define BYPASS_SETUP_CYCLES  2   // clocks between cs_n fall and first sclk edge
`define BYPASS_TALLY_BITS    8   // win/lose counters, wrap around

`endif

//--- rtl/bypass_controller.sv
`timescale 1ns/1ns
`include "bypass_consts.svh"

module bypass_controller (
    input  logic                          clk,
    input  logic                          reset,
    // host command side
    input  logic                          bypass_enable,
    input  logic [`BYPASS_WORD_BITS-1:0]  command_data,
    input  logic                          command_valid,
    input  bypass_pkg::spi_mode_e         spi_mode,
    input  logic                          cs_manual,
    input  logic                          cs_level,
    input  logic [`BYPASS_GROUP_BITS-1:0] query_group,
    // host status side
    output logic [`BYPASS_WORD_BITS-1:0]  response_data,
    output logic                          response_valid,
    output logic                          busy,
    output logic [`BYPASS_GROUP_BITS-1:0] current_group,
    output bypass_pkg::electrode_func_e   current_function,
    output bypass_pkg::electrode_func_e   query_function,
    output logic [`BYPASS_TALLY_BITS-1:0] win_count,
    output logic [`BYPASS_TALLY_BITS-1:0] lose_count,
    // spi pins
    output logic                          cs_n,
    output logic                          sclk,
    output logic                          mosi,
    input  logic                          miso
);

    logic                         cmd_accept;
    logic [`BYPASS_WORD_BITS-1:0] cmd_word;

    // --------------------
    // spi master
    // --------------------
    spi_word_engine i_engine (
        .clk            (clk),
        .reset          (reset),
        .bypass_enable  (bypass_enable),
        .command_data   (command_data),
        .command_valid  (command_valid),
        .spi_mode       (spi_mode),
        .cs_manual      (cs_manual),
        .cs_level       (cs_level),
        .miso           (miso),
        .cs_n           (cs_n),
        .sclk           (sclk),
        .mosi           (mosi),
        .busy           (busy),
        .cmd_accept     (cmd_accept),
        .cmd_word       (cmd_word),
        .response_data  (response_data),
        .response_valid (response_valid)
    );

    // group config, sees only accepted words
    electrode_group_table i_table (
        .clk              (clk),
        .reset            (reset),
        .cmd_accept       (cmd_accept),
        .cmd_word         (cmd_word),
        .query_group      (query_group),
        .current_group    (current_group),
        .current_function (current_function),
        .query_function   (query_function)
    );

    // --------------------
    // win/lose from response msb
    // --------------------
    outcome_tally i_tally (
        .clk            (clk),
        .reset          (reset),
        .response_valid (response_valid),
        .response_msb   (response_data[`BYPASS_WORD_BITS-1]),
        .win_count      (win_count),
        .lose_count     (lose_count)
    );

endmodule

//--- rtl/bypass_pkg.sv
package bypass_pkg;

    // --------------------
    // spi engine states
    // --------------------
    typedef enum logic [2:0] {
        idle        = 3'd0,  // waiting for a host strobe
        cs_assert   = 3'd1,  // cs_n just dropped
        setup       = 3'd2,  // hold sclk at cpol before first edge
        transfer    = 3'd3,  // 64 half periods of sclk
        cs_deassert = 3'd4,  // cs_n back high
        done        = 3'd5   // response_valid pulse
    } spi_state_e;

    // clock mode, bit 1 = cpol, bit 0 = cpha
    typedef enum logic [1:0] {
        mode0 = 2'b00,
        mode1 = 2'b01,
        mode2 = 2'b10,
        mode3 = 2'b11
    } spi_mode_e;

    // top nibble of a host command
    // anything other than op_electrode_group just goes out on spi
    typedef enum logic [3:0] {
        op_pass_through    = 4'd0,
        op_electrode_group = 4'd1
    } cmd_opcode_e;

    // --------------------
    // electrode group role
    // --------------------
    typedef enum logic [1:0] {
        func_collect   = 2'b00,  // record potentials
        func_stimulate = 2'b01,  // drive stimulation
        func_high_z    = 2'b10,  // disconnected
        func_reserved  = 2'b11
    } electrode_func_e;

endpackage

//--- rtl/electrode_group_table.sv
`timescale 1ns/1ns
`include "bypass_consts.svh"

module electrode_group_table (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          cmd_accept,
    input  logic [`BYPASS_WORD_BITS-1:0]  cmd_word,
    input  logic [`BYPASS_GROUP_BITS-1:0] query_group,
    output logic [`BYPASS_GROUP_BITS-1:0] current_group,
    output bypass_pkg::electrode_func_e   current_function,
    output bypass_pkg::electrode_func_e   query_function
);

    // one function entry per group
    bypass_pkg::electrode_func_e func_table [`BYPASS_GROUPS];

    bypass_pkg::cmd_opcode_e     opcode;
    logic [`BYPASS_GROUP_BITS-1:0] cmd_group;
    bypass_pkg::electrode_func_e cmd_func;
    logic                        group_cmd;
    logic                        group_in_range;

    // --------------------
    // field decode
    // --------------------
    assign opcode    = bypass_pkg::cmd_opcode_e'(cmd_word[`BYPASS_OPCODE_MSB:`BYPASS_OPCODE_LSB]);
    assign cmd_group = cmd_word[`BYPASS_GROUP_MSB:`BYPASS_GROUP_LSB];
    assign cmd_func  = bypass_pkg::electrode_func_e'(cmd_word[`BYPASS_FUNC_MSB:`BYPASS_FUNC_LSB]);

    assign group_cmd      = cmd_accept && (opcode == bypass_pkg::op_electrode_group);
    assign group_in_range = cmd_group < `BYPASS_GROUPS;  // 10..15 never touch the table

    // current selection follows every group command, even out of range
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            current_group    <= '0;
            current_function <= bypass_pkg::func_collect;
        end else if (group_cmd) begin
            current_group    <= cmd_group;
            current_function <= cmd_func;
        end
    end

    // --------------------
    // table write
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int g = 0; g < `BYPASS_GROUPS; g++) begin
                func_table[g] <= bypass_pkg::func_collect;  // all groups record after reset
            end
        end else if (group_cmd && group_in_range) begin
            func_table[cmd_group] <= cmd_func;
        end
    end

    // host readback, no clock
    always_comb begin
        if (query_group < `BYPASS_GROUPS) begin
            query_function = func_table[query_group];
        end else begin
            query_function = bypass_pkg::func_collect;  // unknown group reads as default
        end
    end

endmodule

//--- rtl/outcome_tally.sv
`timescale 1ns/1ns
`include "bypass_consts.svh"

module outcome_tally (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          response_valid,
    input  logic                          response_msb,
    output logic [`BYPASS_TALLY_BITS-1:0] win_count,
    output logic [`BYPASS_TALLY_BITS-1:0] lose_count
);

    logic win_hit;
    logic lose_hit;

    // one of the two per finished word
    assign win_hit  = response_valid && response_msb;
    assign lose_hit = response_valid && !response_msb;

    // --------------------
    // counters
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            win_count  <= '0;
            lose_count <= '0;
        end else begin
            if (win_hit) begin
                win_count <= win_count + 1'b1;  // wraps at 255
            end
            if (lose_hit) begin
                lose_count <= lose_count + 1'b1;
            end
        end
    end

endmodule

//--- rtl/spi_word_engine.sv
`timescale 1ns/1ns
`include "bypass_consts.svh"

module spi_word_engine (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         bypass_enable,
    input  logic [`BYPASS_WORD_BITS-1:0] command_data,
    input  logic                         command_valid,
    input  bypass_pkg::spi_mode_e        spi_mode,
    input  logic                         cs_manual,
    input  logic                         cs_level,
    input  logic                         miso,
    output logic                         cs_n,
    output logic                         sclk,
    output logic                         mosi,
    output logic                         busy,
    output logic                         cmd_accept,
    output logic [`BYPASS_WORD_BITS-1:0] cmd_word,
    output logic [`BYPASS_WORD_BITS-1:0] response_data,
    output logic                         response_valid
);

    localparam int unsigned EDGES   = 2 * `BYPASS_WORD_BITS;  // sclk edges per word
    localparam int unsigned EDGE_W  = $clog2(EDGES);
    localparam int unsigned SETUP_W = $clog2(`BYPASS_SETUP_CYCLES + 1);
    localparam int unsigned MSB     = `BYPASS_WORD_BITS - 1;

    bypass_pkg::spi_state_e state;
    bypass_pkg::spi_mode_e  mode_q;  // held for the whole word

    logic [MSB:0]         tx_shift;   // next mosi bit sits at the top
    logic [MSB:0]         rx_shift;   // miso enters at bit 0, ends at 31
    logic [EDGE_W-1:0]    edge_cnt;   // half period index, bit = edge_cnt[5:1]
    logic [SETUP_W-1:0]   setup_cnt;

    logic start;
    logic setup_last;
    logic edge_last;
    logic sclk_edge;
    logic lead_edge;
    logic cpol;
    logic cpha;
    logic shift_now;
    logic sample_now;
    logic idle_cs_n;

    // --------------------
    // control decode
    // --------------------
    assign start      = (state == bypass_pkg::idle) && command_valid && bypass_enable;
    assign setup_last = setup_cnt == SETUP_W'(`BYPASS_SETUP_CYCLES - 1);
    assign edge_last  = (state == bypass_pkg::transfer) && (edge_cnt == EDGE_W'(EDGES - 1));

    // an sclk edge lands on the clk edge that opens each transfer cycle
    assign sclk_edge = ((state == bypass_pkg::setup) && setup_last) ||
                       ((state == bypass_pkg::transfer) && !edge_last);

    // edge 0 comes out of setup, edge k+1 out of transfer cycle k
    assign lead_edge = (state == bypass_pkg::setup) || edge_cnt[0];

    assign cpol = mode_q[1];
    assign cpha = mode_q[0];

    // cpha 0 samples on leading, cpha 1 on trailing; shift on the other one
    assign shift_now  = sclk_edge && (lead_edge == cpha);
    assign sample_now = sclk_edge && (lead_edge != cpha);

    assign idle_cs_n = cs_manual ? cs_level : 1'b1;  // manual cs only between words

    always_comb begin
        busy = (state == bypass_pkg::cs_assert) || (state == bypass_pkg::setup) ||
               (state == bypass_pkg::transfer)  || (state == bypass_pkg::cs_deassert);
    end

    // --------------------
    // fsm and pins
    // --------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state          <= bypass_pkg::idle;
            mode_q         <= bypass_pkg::mode0;
            edge_cnt       <= '0;
            setup_cnt      <= '0;
            cs_n           <= 1'b1;
            sclk           <= 1'b0;
            mosi           <= 1'b0;
            cmd_accept     <= 1'b0;
            response_valid <= 1'b0;
            response_data  <= '0;
        end else begin
            cmd_accept     <= 1'b0;  // single cycle strobes
            response_valid <= 1'b0;
            case (state)
                bypass_pkg::idle: begin
                    sclk <= spi_mode[1];  // rest at cpol
                    cs_n <= idle_cs_n;
                    if (start) begin
                        state      <= bypass_pkg::cs_assert;
                        mode_q     <= spi_mode;
                        cmd_accept <= 1'b1;
                        cs_n       <= 1'b0;
                        // cpha 0 presents bit 31 together with cs_n
                        mosi       <= spi_mode[0] ? 1'b0 : command_data[MSB];
                    end
                end
                bypass_pkg::cs_assert: begin
                    setup_cnt <= '0;
                    edge_cnt  <= '0;
                    state     <= bypass_pkg::setup;
                end
                bypass_pkg::setup: begin
                    if (setup_last) begin
                        state <= bypass_pkg::transfer;
                    end else begin
                        setup_cnt <= setup_cnt + 1'b1;
                    end
                end
                bypass_pkg::transfer: begin
                    if (edge_last) begin
                        state <= bypass_pkg::cs_deassert;
                        cs_n  <= 1'b1;
                        mosi  <= 1'b0;
                    end else begin
                        edge_cnt <= edge_cnt + 1'b1;
                    end
                end
                bypass_pkg::cs_deassert: begin
                    response_data  <= rx_shift;  // last sample already in
                    response_valid <= 1'b1;
                    state          <= bypass_pkg::done;
                end
                bypass_pkg::done: begin
                    cs_n  <= idle_cs_n;
                    state <= bypass_pkg::idle;
                end
                default: begin
                    state <= bypass_pkg::idle;
                end
            endcase
            if (sclk_edge) begin
                sclk <= lead_edge ? ~cpol : cpol;
            end
            if (shift_now) begin
                mosi <= tx_shift[MSB];
            end
        end
    end

    // --------------------
    // data path
    // --------------------
    always_ff @(posedge clk) begin
        if (start) begin
            cmd_word <= command_data;
            // bit 31 already on mosi for cpha 0
            tx_shift <= spi_mode[0] ? command_data : {command_data[MSB-1:0], 1'b0};
        end else if (shift_now) begin
            tx_shift <= {tx_shift[MSB-1:0], 1'b0};
        end
        if (sample_now) begin
            rx_shift <= {rx_shift[MSB-1:0], miso};  // msb first
        end
    end

endmodule

//--- tb.f
+incdir+rtl
rtl/bypass_pkg.sv
rtl/electrode_group_table.sv
rtl/spi_word_engine.sv
rtl/outcome_tally.sv
rtl/bypass_controller.sv
testbench/bypass_assertions.sv
testbench/tb_bypass_controller.sv

//--- testbench/bypass_assertions.sv
`timescale 1ns/1ns

module bypass_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  cs_n,
    input logic                  busy,
    input logic                  sclk,
    input logic                  cs_manual,
    input logic                  response_valid,
    input bypass_pkg::spi_mode_e spi_mode
);

    // --------------------
    // spi pin checks
    // --------------------

    // automatic cs only drops inside a transfer
    property cs_low_busy;
        @(posedge clk) disable iff (reset)
            (!cs_n && !cs_manual && !$past(cs_manual)) |-> busy;
    endproperty

    property valid_single;
        @(posedge clk) disable iff (reset)
            response_valid |=> !response_valid;
    endproperty

    // sclk follows cpol one clock late when idle
    property sclk_rest;
        @(posedge clk) disable iff (reset)
            (!busy && !$past(busy)) |-> (sclk == $past(spi_mode[1]));
    endproperty

    a_cs_low_busy: assert property (cs_low_busy) else $error("cs_n low outside a transfer");
    a_valid_single: assert property (valid_single) else $error("response_valid longer than 1");
    a_sclk_rest: assert property (sclk_rest) else $error("sclk left cpol while idle");

endmodule

bind spi_word_engine bypass_assertions i_assertions (
    .clk            (clk),
    .reset          (reset),
    .cs_n           (cs_n),
    .busy           (busy),
    .sclk           (sclk),
    .cs_manual      (cs_manual),
    .response_valid (response_valid),
    .spi_mode       (spi_mode)
);

//--- testbench/tb_bypass_controller.sv
`timescale 1ns/1ns
`include "bypass_consts.svh"

module tb_bypass_controller;

    localparam int N_TRANSFERS = 18;               // 4 modes, 5 group, 1 busy, 8 random
    localparam int CYCLE_LIMIT = 200 * N_TRANSFERS;
    localparam int WORD_TIMEOUT = 200;

    logic                          clk;
    logic                          reset;
    logic                          bypass_enable;
    logic [`BYPASS_WORD_BITS-1:0]  command_data;
    logic                          command_valid;
    bypass_pkg::spi_mode_e         spi_mode;
    logic                          cs_manual;
    logic                          cs_level;
    logic [`BYPASS_GROUP_BITS-1:0] query_group;
    logic [`BYPASS_WORD_BITS-1:0]  response_data;
    logic                          response_valid;
    logic                          busy;
    logic [`BYPASS_GROUP_BITS-1:0] current_group;
    bypass_pkg::electrode_func_e   current_function;
    bypass_pkg::electrode_func_e   query_function;
    logic [`BYPASS_TALLY_BITS-1:0] win_count;
    logic [`BYPASS_TALLY_BITS-1:0] lose_count;
    logic                          cs_n;
    logic                          sclk;
    logic                          mosi;
    logic                          miso;

    int    errors;
    int    checks;
    int    cycles;
    string cur_test;

    // reference state
    bypass_pkg::electrode_func_e   exp_table [`BYPASS_GROUPS];
    logic [`BYPASS_GROUP_BITS-1:0] exp_cur_group;
    bypass_pkg::electrode_func_e   exp_cur_func;
    logic [`BYPASS_TALLY_BITS-1:0] exp_wins;
    logic [`BYPASS_TALLY_BITS-1:0] exp_losses;
    logic [`BYPASS_WORD_BITS-1:0]  exp_resp_q [$];
    logic [`BYPASS_WORD_BITS-1:0]  exp_cmd_q [$];
    logic [`BYPASS_WORD_BITS-1:0]  exp_word;
    logic [`BYPASS_WORD_BITS-1:0]  sent_word;

    // slave model
    bypass_pkg::spi_mode_e        cur_mode;
    logic [`BYPASS_WORD_BITS-1:0] slave_word;
    logic [`BYPASS_WORD_BITS-1:0] slave_rx;
    int                           tx_idx;
    logic                         lead;

    bypass_controller i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // --------------------
    // spi slave model
    // --------------------
    always @(posedge busy) begin
        tx_idx   = `BYPASS_WORD_BITS - 1;
        slave_rx = '0;
        if (!cur_mode[0]) begin
            miso <= slave_word[tx_idx];  // cpha 0 presents msb with cs
        end
    end

    always @(sclk) begin
        if (busy === 1'b1) begin
            lead = (sclk != cur_mode[1]);
            if (lead == cur_mode[0]) begin
                if (cur_mode[0]) begin
                    miso   <= slave_word[tx_idx];  // cpha 1 moves on leading
                    tx_idx = tx_idx - 1;
                end else if (tx_idx > 0) begin
                    tx_idx = tx_idx - 1;
                    miso   <= slave_word[tx_idx];
                end
            end else begin
                slave_rx = {slave_rx[`BYPASS_WORD_BITS-2:0], mosi};
            end
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [`BYPASS_WORD_BITS-1:0] model_command(
        input logic [`BYPASS_WORD_BITS-1:0] cmd,
        input logic [`BYPASS_WORD_BITS-1:0] slave
    );
        logic [`BYPASS_GROUP_BITS-1:0] grp;
        bypass_pkg::electrode_func_e   fn;
        grp = cmd[`BYPASS_GROUP_MSB:`BYPASS_GROUP_LSB];
        fn  = bypass_pkg::electrode_func_e'(cmd[`BYPASS_FUNC_MSB:`BYPASS_FUNC_LSB]);
        if (cmd[`BYPASS_OPCODE_MSB:`BYPASS_OPCODE_LSB] == 4'd1) begin
            exp_cur_group = grp;
            exp_cur_func  = fn;
            if (grp < `BYPASS_GROUPS) begin
                exp_table[grp] = fn;
            end
        end
        if (slave[`BYPASS_WORD_BITS-1]) begin
            exp_wins = exp_wins + 1'b1;
        end else begin
            exp_losses = exp_losses + 1'b1;
        end
        return slave;  // master returns exactly what the slave shifted
    endfunction

    function automatic bypass_pkg::electrode_func_e ref_query(input int g);
        if (g < `BYPASS_GROUPS) begin
            return exp_table[g];
        end
        return bypass_pkg::func_collect;
    endfunction

    // --------------------
    // compare tasks
    // --------------------
    task automatic check_word(input string what, input logic [`BYPASS_WORD_BITS-1:0] exp,
                              input logic [`BYPASS_WORD_BITS-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
        end
    endtask

    task automatic check_func(input string what, input bypass_pkg::electrode_func_e exp,
                              input bypass_pkg::electrode_func_e act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %s, actual %s", cur_test, what,
                     exp.name(), act.name());
        end
    endtask

    task automatic check_count(input string what, input logic [`BYPASS_TALLY_BITS-1:0] exp,
                               input logic [`BYPASS_TALLY_BITS-1:0] act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("mismatch %s %s: expected %b, actual %b", cur_test, what, exp, act);
        end
    endtask

    // result compare, one per finished word
    always @(negedge clk) begin
        if (!reset && response_valid === 1'b1) begin
            if (exp_resp_q.size() == 0) begin
                errors++;
                $display("%s: response_valid with no command outstanding", cur_test);
            end else begin
                exp_word  = exp_resp_q.pop_front();
                sent_word = exp_cmd_q.pop_front();
                check_word("response_data", exp_word, response_data);
                check_word("mosi capture", sent_word, slave_rx);
                check_word("current_group", 32'(exp_cur_group), 32'(current_group));
                check_func("current_function", exp_cur_func, current_function);
                @(negedge clk);  // tally lands one cycle later
                check_count("win_count", exp_wins, win_count);
                check_count("lose_count", exp_losses, lose_count);
            end
        end
    end

    // --------------------
    // stimulus helpers
    // --------------------
    task automatic raw_strobe(input logic [`BYPASS_WORD_BITS-1:0] cmd,
                              input bypass_pkg::spi_mode_e mode);
        @(posedge clk);
        spi_mode      <= mode;  // sclk settles at the new cpol before cs_n falls
        @(posedge clk);
        command_data  <= cmd;
        command_valid <= 1'b1;
        @(posedge clk);
        command_valid <= 1'b0;
    endtask

    task automatic issue(input logic [`BYPASS_WORD_BITS-1:0] cmd,
                         input bypass_pkg::spi_mode_e mode);
        cur_mode   = mode;
        slave_word = $urandom;
        exp_cmd_q.push_back(cmd);
        exp_resp_q.push_back(model_command(cmd, slave_word));
        raw_strobe(cmd, mode);
    endtask

    task automatic wait_response();
        int n;
        n = 0;
        while (response_valid !== 1'b1 && n < WORD_TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (n >= WORD_TIMEOUT) begin
            errors++;
            $display("%s: transfer did not finish within %0d cycles", cur_test, WORD_TIMEOUT);
        end else begin
            repeat (2) @(negedge clk);
        end
    endtask

    task automatic scan_table();
        for (int g = 0; g < 16; g++) begin
            @(posedge clk);
            query_group <= g[`BYPASS_GROUP_BITS-1:0];
            @(negedge clk);
            check_func($sformatf("query_function[%0d]", g), ref_query(g), query_function);
        end
    endtask

    function automatic logic [`BYPASS_WORD_BITS-1:0] pass_word();
        logic [`BYPASS_WORD_BITS-1:0] w;
        w = $urandom;
        if (w[`BYPASS_OPCODE_MSB:`BYPASS_OPCODE_LSB] == 4'd1) begin
            w[`BYPASS_OPCODE_MSB:`BYPASS_OPCODE_LSB] = 4'd2;  // keep it pass-through
        end
        return w;
    endfunction

    function automatic logic [`BYPASS_WORD_BITS-1:0] group_word(input int g, input int f);
        return {4'd1, 4'(g), 2'(f), 22'($urandom)};
    endfunction

    // run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > CYCLE_LIMIT + 100) begin
            $display("run exceeded %0d cycles, stimulus stalled", CYCLE_LIMIT + 100);
            $display(">>> FAIL");
            $finish;
        end
    end

    // --------------------
    // main sequence
    // --------------------
    initial begin
        void'($urandom(78));
        errors = 0;
        checks = 0;
        cycles = 0;
        cur_test = "reset";
        reset = 1'b1;
        bypass_enable = 1'b1;
        command_data = '0;
        command_valid = 1'b0;
        spi_mode = bypass_pkg::mode0;
        cur_mode = bypass_pkg::mode0;
        cs_manual = 1'b0;
        cs_level = 1'b1;
        query_group = '0;
        miso = 1'b0;
        slave_word = '0;
        exp_cur_group = '0;
        exp_cur_func = bypass_pkg::func_collect;
        exp_wins = '0;
        exp_losses = '0;
        for (int g = 0; g < `BYPASS_GROUPS; g++) begin
            exp_table[g] = bypass_pkg::func_collect;
        end
        repeat (8) @(negedge clk);
        check_bit("sclk in reset", 1'b0, sclk);
        repeat (8) @(posedge clk);
        reset <= 1'b0;
        repeat (2) @(negedge clk);
        check_bit("cs_n", 1'b1, cs_n);
        check_bit("busy", 1'b0, busy);
        check_bit("response_valid", 1'b0, response_valid);
        check_word("current_group", 32'd0, 32'(current_group));
        check_func("current_function", bypass_pkg::func_collect, current_function);
        check_count("win_count", 8'd0, win_count);
        check_count("lose_count", 8'd0, lose_count);
        scan_table();

        cur_test = "manual cs";
        @(posedge clk);
        cs_manual <= 1'b1;
        cs_level  <= 1'b0;
        repeat (2) @(negedge clk);
        check_bit("cs_n low", 1'b0, cs_n);
        @(posedge clk);
        cs_level <= 1'b1;
        repeat (2) @(negedge clk);
        check_bit("cs_n high", 1'b1, cs_n);
        @(posedge clk);
        cs_manual <= 1'b0;

        cur_test = "spi modes";
        for (int m = 0; m < 4; m++) begin
            issue(pass_word(), bypass_pkg::spi_mode_e'(m));
            wait_response();
        end

        cur_test = "group table";
        issue(group_word(0, 1), bypass_pkg::mode1);
        wait_response();
        issue(group_word(3, 2), bypass_pkg::mode2);
        wait_response();
        issue(group_word(9, 3), bypass_pkg::mode3);
        wait_response();
        issue(group_word(7, 1), bypass_pkg::mode0);
        wait_response();
        issue(group_word(12, 2), bypass_pkg::mode0);  // out of range, table untouched
        wait_response();
        scan_table();

        cur_test = "enable low";
        @(posedge clk);
        bypass_enable <= 1'b0;
        raw_strobe(group_word(5, 1), bypass_pkg::mode0);
        repeat (80) begin
            @(negedge clk);
            check_bit("cs_n", 1'b1, cs_n);
        end
        @(posedge clk);
        bypass_enable <= 1'b1;
        scan_table();

        cur_test = "strobe while busy";
        issue(pass_word(), bypass_pkg::mode1);
        repeat (10) @(posedge clk);
        raw_strobe(group_word(5, 2), bypass_pkg::mode1);  // must be dropped
        wait_response();
        repeat (80) begin
            @(negedge clk);
            check_bit("busy after", 1'b0, busy);
        end
        scan_table();

        cur_test = "random words";
        for (int i = 0; i < 8; i++) begin
            issue($urandom, bypass_pkg::spi_mode_e'($urandom_range(3)));
            wait_response();
        end
        scan_table();

        repeat (4) @(negedge clk);
        $display("checks %0d, errors %0d, responses left %0d", checks, errors,
                 exp_resp_q.size());
        if (errors == 0 && exp_resp_q.size() == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
